//--- mboxPkg.sv
`default_nettype none

package mboxPkg;

  // Default physical word address width
  localparam int PaWidth = 22;

  // Default request queue depth
  localparam int QueueDepth = 4;

  // Physical word address whose low two bits pick the word in a quad-word
  typedef logic [PaWidth-1:0] paddrT;

  // Quad-word request mask where bit n requests word n
  typedef logic [3:0] rqMaskT;

  // Word select within a quad-word
  typedef logic [1:0] wordSelT;

  // Memory start consumer states
  typedef enum logic [1:0] {
    Idle,
    WaitPhase,
    Started,
    Draining
  } memStateT;

endpackage

`default_nettype wire

//--- reqIssue.sv
`default_nettype none

module reqIssue import mboxPkg::*; #(
  parameter int addrWidth = PaWidth
) (
  input  logic                 clk,
  input  logic                 rstN,

  input  logic                 reqValid,
  output logic                 reqReady,
  input  logic [addrWidth-1:0] reqAddr,
  input  logic                 reqWrite,
  input  rqMaskT               reqMask,
  input  logic                 reqForceBadPar,

  output logic                 issueValid,
  input  logic                 issueReady,
  output logic [addrWidth-1:0] issueAddr,
  output rqMaskT               issueMask,
  output logic                 issueRead,
  output logic                 issueWrite,
  output logic                 issuePar
);

  logic   armed;
  logic   accept;
  rqMaskT wordBit;
  rqMaskT normMask;
  logic   addrPar;

  // Held request may be replaced in the cycle the queue takes it
  assign reqReady = armed && (!issueValid || issueReady);
  assign accept   = reqValid && reqReady;

  // Single word picked by the low address bits
  assign wordBit = rqMaskT'(1) << reqAddr[1:0];

  always_comb begin
    if (reqWrite || reqMask == '0) begin
      normMask = wordBit;
    end else begin
      normMask = reqMask;
    end
  end

  assign addrPar = ^{reqAddr, normMask, !reqWrite, reqWrite};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      armed      <= 1'b0;
      issueValid <= 1'b0;
    end else begin
      armed <= 1'b1;
      if (accept) begin
        issueValid <= 1'b1;
      end else if (issueReady) begin
        issueValid <= 1'b0;
      end
    end
  end

  // Request hold register
  always_ff @(posedge clk) begin
    if (accept) begin
      issueAddr  <= reqAddr;
      issueMask  <= normMask;
      issueRead  <= !reqWrite;
      issueWrite <= reqWrite;
      issuePar   <= addrPar ^ reqForceBadPar;
    end
  end

endmodule

`default_nettype wire

//--- reqQueue.sv
`default_nettype none

module reqQueue import mboxPkg::*; #(
  parameter int addrWidth = PaWidth,
  parameter int depth     = QueueDepth
) (
  input  logic                 clk,
  input  logic                 rstN,

  input  logic                 issueValid,
  output logic                 issueReady,
  input  logic [addrWidth-1:0] issueAddr,
  input  rqMaskT               issueMask,
  input  logic                 issueRead,
  input  logic                 issueWrite,
  input  logic                 issuePar,

  output logic                 qValid,
  input  logic                 qReady,
  output logic [addrWidth-1:0] qAddr,
  output rqMaskT               qMask,
  output logic                 qRead,
  output logic                 qWrite,
  output logic                 qPar
);

  localparam int PtrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int CntWidth = $clog2(depth + 1);

  logic [addrWidth-1:0] addrMem [depth];
  rqMaskT               maskMem [depth];
  logic                 readMem [depth];
  logic                 writeMem [depth];
  logic                 parMem [depth];

  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [CntWidth-1:0] count;
  logic                doWrite;
  logic                doRead;

  // Pointer step with wrap at the last entry
  function automatic logic [PtrWidth-1:0] bump(logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign issueReady = (count != CntWidth'(depth));
  assign qValid     = (count != '0);
  assign doWrite    = issueValid && issueReady;
  assign doRead     = qValid && qReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= bump(wrPtr);
      end
      if (doRead) begin
        rdPtr <= bump(rdPtr);
      end
      if (doWrite && !doRead) begin
        count <= count + 1'b1;
      end else if (doRead && !doWrite) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (doWrite) begin
      addrMem[wrPtr]  <= issueAddr;
      maskMem[wrPtr]  <= issueMask;
      readMem[wrPtr]  <= issueRead;
      writeMem[wrPtr] <= issueWrite;
      parMem[wrPtr]   <= issuePar;
    end
  end

  assign qAddr  = addrMem[rdPtr];
  assign qMask  = maskMem[rdPtr];
  assign qRead  = readMem[rdPtr];
  assign qWrite = writeMem[rdPtr];
  assign qPar   = parMem[rdPtr];

endmodule

`default_nettype wire

//--- memStartCtl.sv
`default_nettype none

module memStartCtl import mboxPkg::*; #(
  parameter int addrWidth = PaWidth
) (
  input  logic                 clk,
  input  logic                 rstN,

  input  logic                 qValid,
  output logic                 qReady,
  input  logic [addrWidth-1:0] qAddr,
  input  rqMaskT               qMask,
  input  logic                 qRead,
  input  logic                 qWrite,
  input  logic                 qPar,

  output logic                 memStart,
  output logic                 memStartA,
  output logic                 memStartB,
  output logic [addrWidth-1:0] memAddr,
  output rqMaskT               memRq,
  output logic                 memRd,
  output logic                 memWr,
  output logic                 memAdrPar,
  input  logic                 memAckn,
  input  logic                 memDataValid,

  output logic                 coreDataValid,
  output wordSelT              coreWord
);

  memStateT state;

  logic   aPhase;
  logic   lastWasA;
  logic   comingA;
  logic   phaseFree;
  logic   take;
  logic   acknPulse;
  logic   lastAckn;
  logic   lastData;
  logic   dvMinus1;
  rqMaskT rqLeft;
  rqMaskT dataLeft;

  // Next set mask bit after from with wrap-around
  // From itself is checked last
  function automatic wordSelT nextSet(rqMaskT mask, wordSelT from);
    wordSelT pick;
    wordSelT w;
    logic    found;
    pick  = from;
    found = 1'b0;
    for (int i = 1; i <= 4; i++) begin
      w = from + wordSelT'(i);
      if (!found && mask[w]) begin
        pick  = w;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  assign qReady = (state == Idle);
  assign take   = qValid && qReady;

  assign memStart  = memStartA || memStartB;
  assign comingA   = !aPhase;
  // Back-to-back starts alternate phases
  assign phaseFree = (comingA != lastWasA);

  assign acknPulse = memAckn && memStart;
  assign lastAckn  = acknPulse && ((rqLeft & (rqLeft - 1'b1)) == '0);
  assign lastData  = coreDataValid && ((dataLeft & (dataLeft - 1'b1)) == '0);

  // Phase A in the first cycle out of reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      aPhase <= 1'b1;
    end else begin
      aPhase <= !aPhase;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state     <= Idle;
      memStartA <= 1'b0;
      memStartB <= 1'b0;
      lastWasA  <= 1'b0;
      rqLeft    <= '0;
    end else begin
      case (state)
        Idle: begin
          if (take) begin
            state  <= WaitPhase;
            rqLeft <= qMask;
          end
        end
        WaitPhase: begin
          if (phaseFree) begin
            state     <= Started;
            memStartA <= comingA;
            memStartB <= !comingA;
            lastWasA  <= comingA;
          end
        end
        Started: begin
          if (lastAckn) begin
            memStartA <= 1'b0;
            memStartB <= 1'b0;
            rqLeft    <= '0;
            state     <= memRd ? Draining : Idle;
          end else if (acknPulse) begin
            // Retire lowest outstanding word
            rqLeft <= rqLeft & (rqLeft - 1'b1);
          end
        end
        Draining: begin
          if (lastData) begin
            state <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // Held request fields for the memory bus
  always_ff @(posedge clk) begin
    if (take) begin
      memAddr   <= qAddr;
      memRq     <= qMask;
      memRd     <= qRead;
      memWr     <= qWrite;
      memAdrPar <= qPar;
    end
  end

  // Two-stage data valid delay and core word walk
  always_ff @(posedge clk) begin
    if (!rstN) begin
      dvMinus1      <= 1'b0;
      coreDataValid <= 1'b0;
      dataLeft      <= '0;
      coreWord      <= '0;
    end else begin
      dvMinus1      <= memDataValid;
      coreDataValid <= dvMinus1;
      if (take) begin
        dataLeft <= qRead ? qMask : '0;
        coreWord <= nextSet(qMask, wordSelT'(qAddr[1:0] - 2'd1));
      end else if (coreDataValid) begin
        dataLeft <= dataLeft & (dataLeft - 1'b1);
        coreWord <= nextSet(memRq, coreWord);
      end
    end
  end

endmodule

`default_nettype wire

//--- mboxMemCtl.sv
`default_nettype none

module mboxMemCtl import mboxPkg::*; #(
  parameter int addrWidth = PaWidth,
  parameter int depth     = QueueDepth
) (
  input  logic                 clk,
  input  logic                 rstN,

  input  logic                 reqValid,
  output logic                 reqReady,
  input  logic [addrWidth-1:0] reqAddr,
  input  logic                 reqWrite,
  input  rqMaskT               reqMask,
  input  logic                 reqForceBadPar,

  output logic                 memStart,
  output logic                 memStartA,
  output logic                 memStartB,
  output logic [addrWidth-1:0] memAddr,
  output rqMaskT               memRq,
  output logic                 memRd,
  output logic                 memWr,
  output logic                 memAdrPar,
  input  logic                 memAckn,
  input  logic                 memDataValid,

  output logic                 coreDataValid,
  output wordSelT              coreWord
);

  logic                 issueValid;
  logic                 issueReady;
  logic [addrWidth-1:0] issueAddr;
  rqMaskT               issueMask;
  logic                 issueRead;
  logic                 issueWrite;
  logic                 issuePar;

  logic                 qValid;
  logic                 qReady;
  logic [addrWidth-1:0] qAddr;
  rqMaskT               qMask;
  logic                 qRead;
  logic                 qWrite;
  logic                 qPar;

  reqIssue #(
    .addrWidth(addrWidth)
  ) uIssue (
    .clk           (clk),
    .rstN          (rstN),
    .reqValid      (reqValid),
    .reqReady      (reqReady),
    .reqAddr       (reqAddr),
    .reqWrite      (reqWrite),
    .reqMask       (reqMask),
    .reqForceBadPar(reqForceBadPar),
    .issueValid    (issueValid),
    .issueReady    (issueReady),
    .issueAddr     (issueAddr),
    .issueMask     (issueMask),
    .issueRead     (issueRead),
    .issueWrite    (issueWrite),
    .issuePar      (issuePar)
  );

  reqQueue #(
    .addrWidth(addrWidth),
    .depth    (depth)
  ) uQueue (
    .clk       (clk),
    .rstN      (rstN),
    .issueValid(issueValid),
    .issueReady(issueReady),
    .issueAddr (issueAddr),
    .issueMask (issueMask),
    .issueRead (issueRead),
    .issueWrite(issueWrite),
    .issuePar  (issuePar),
    .qValid    (qValid),
    .qReady    (qReady),
    .qAddr     (qAddr),
    .qMask     (qMask),
    .qRead     (qRead),
    .qWrite    (qWrite),
    .qPar      (qPar)
  );

  memStartCtl #(
    .addrWidth(addrWidth)
  ) uStart (
    .clk          (clk),
    .rstN         (rstN),
    .qValid       (qValid),
    .qReady       (qReady),
    .qAddr        (qAddr),
    .qMask        (qMask),
    .qRead        (qRead),
    .qWrite       (qWrite),
    .qPar         (qPar),
    .memStart     (memStart),
    .memStartA    (memStartA),
    .memStartB    (memStartB),
    .memAddr      (memAddr),
    .memRq        (memRq),
    .memRd        (memRd),
    .memWr        (memWr),
    .memAdrPar    (memAdrPar),
    .memAckn      (memAckn),
    .memDataValid (memDataValid),
    .coreDataValid(coreDataValid),
    .coreWord     (coreWord)
  );

endmodule

`default_nettype wire

//--- tbClock.sv
`default_nettype none

module tbClock #(
  parameter int halfPeriod  = 50,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clk = 1'b0;
    forever begin
      #(halfPeriod);
      clk = ~clk;
    end
  end

  // Reset released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

`default_nettype wire

//--- mboxMemCtl_sva.sv
`default_nettype none

module mboxMemCtl_sva import mboxPkg::*; #(
  parameter int addrWidth = PaWidth
) (
  input logic                 clk,
  input logic                 rstN,
  input logic                 memStart,
  input logic                 memStartA,
  input logic                 memStartB,
  input logic [addrWidth-1:0] memAddr,
  input rqMaskT               memRq,
  input logic                 memRd,
  input logic                 memWr,
  input logic                 memAdrPar,
  input logic                 memDataValid,
  input logic                 coreDataValid
);
  timeunit 1ns;
  timeprecision 1ns;

  int errCount = 0;

  singlePhase: assert property (@(posedge clk) disable iff (!rstN)
    !(memStartA && memStartB))
    else begin
      $error("memStart raised in phase A and phase B at once");
      errCount++;
    end

  // Held request fields on the memory bus
  stableFields: assert property (@(posedge clk) disable iff (!rstN)
    (memStart ##1 memStart) |-> $stable({memAddr, memRq, memRd, memWr, memAdrPar}))
    else begin
      $error("memory request fields changed while memStart was high");
      errCount++;
    end

  dataDelay: assert property (@(posedge clk) disable iff (!rstN)
    memDataValid |-> ##2 coreDataValid)
    else begin
      $error("coreDataValid missing two cycles after memDataValid");
      errCount++;
    end

  dataCause: assert property (@(posedge clk) disable iff (!rstN)
    coreDataValid |-> $past(memDataValid, 2))
    else begin
      $error("coreDataValid without memDataValid two cycles before");
      errCount++;
    end

  resetQuiet: assert property (@(posedge clk)
    !rstN |=> (!memStartA && !memStartB && !coreDataValid))
    else begin
      $error("control output high after a reset cycle");
      errCount++;
    end

endmodule

bind memStartCtl mboxMemCtl_sva #(
  .addrWidth(addrWidth)
) uSva (
  .clk          (clk),
  .rstN         (rstN),
  .memStart     (memStart),
  .memStartA    (memStartA),
  .memStartB    (memStartB),
  .memAddr      (memAddr),
  .memRq        (memRq),
  .memRd        (memRd),
  .memWr        (memWr),
  .memAdrPar    (memAdrPar),
  .memDataValid (memDataValid),
  .coreDataValid(coreDataValid)
);

`default_nettype wire

//--- mboxMemCtl_tb.sv
`default_nettype none

module mboxMemCtl_tb import mboxPkg::*; ();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int StepLimit = 2000;

  logic    clk;
  logic    rstN;
  logic    reqValid;
  logic    reqReady;
  paddrT   reqAddr;
  logic    reqWrite;
  rqMaskT  reqMask;
  logic    reqForceBadPar;
  logic    memStart;
  logic    memStartA;
  logic    memStartB;
  paddrT   memAddr;
  rqMaskT  memRq;
  logic    memRd;
  logic    memWr;
  logic    memAdrPar;
  logic    memAckn;
  logic    memDataValid;
  logic    coreDataValid;
  wordSelT coreWord;

  // Expected fields in request order
  paddrT   expAddrQ[$];
  rqMaskT  expMaskQ[$];
  logic    expWriteQ[$];
  logic    expParQ[$];
  wordSelT coreWordQ[$];

  logic [31:0] stimSeed;
  logic [31:0] memSeed;
  logic        slowMem;
  logic        memBusy;
  int          stallCount;

  tbClock uClock (
    .clk (clk),
    .rstN(rstN)
  );

  mboxMemCtl #(
    .addrWidth(PaWidth),
    .depth    (QueueDepth)
  ) u_dut (
    .clk           (clk),
    .rstN          (rstN),
    .reqValid      (reqValid),
    .reqReady      (reqReady),
    .reqAddr       (reqAddr),
    .reqWrite      (reqWrite),
    .reqMask       (reqMask),
    .reqForceBadPar(reqForceBadPar),
    .memStart      (memStart),
    .memStartA     (memStartA),
    .memStartB     (memStartB),
    .memAddr       (memAddr),
    .memRq         (memRq),
    .memRd         (memRd),
    .memWr         (memWr),
    .memAdrPar     (memAdrPar),
    .memAckn       (memAckn),
    .memDataValid  (memDataValid),
    .coreDataValid (coreDataValid),
    .coreWord      (coreWord)
  );

  function automatic logic [31:0] lcgNext(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Writes and empty reads become the addressed word
  function automatic rqMaskT expectMask(paddrT addr, logic write, rqMaskT mask);
    rqMaskT one;
    one = 4'b0001;
    if (write || mask == 4'b0000) begin
      return one << addr[1:0];
    end
    return mask;
  endfunction

  function automatic logic expectPar(paddrT addr, rqMaskT mask, logic write, logic bad);
    logic p;
    p = bad;
    for (int i = 0; i < PaWidth; i++) begin
      p = p ^ addr[i];
    end
    for (int i = 0; i < 4; i++) begin
      p = p ^ mask[i];
    end
    return p ^ write ^ !write;
  endfunction

  function automatic int memGap();
    memSeed = lcgNext(memSeed);
    if (slowMem) begin
      return 4 + int'(memSeed[27:24]);
    end
    return int'(memSeed[25:24]);
  endfunction

  task automatic failValue(string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic failTimeout(string what);
    $display("Timed out at %0t ns waiting for %s", $time, what);
    $display("Test FAILED");
    $fatal(1, "timeout");
  endtask

  // Core word order ascending with wrap from the addressed word
  task automatic pushWalk(paddrT addr, rqMaskT mask);
    wordSelT w;
    for (int i = 0; i < 4; i++) begin
      w = wordSelT'(addr[1:0] + i);
      if (mask[w]) begin
        coreWordQ.push_back(w);
      end
    end
  endtask

  task automatic sendReq(paddrT addr, logic write, rqMaskT mask, logic bad);
    int waited;
    reqValid       = 1'b1;
    reqAddr        = addr;
    reqWrite       = write;
    reqMask        = mask;
    reqForceBadPar = bad;
    waited         = 0;
    while (!reqReady) begin
      stallCount++;
      @(negedge clk);
      waited++;
      if (waited > StepLimit) begin
        failTimeout("reqReady");
      end
    end
    expAddrQ.push_back(addr);
    expMaskQ.push_back(expectMask(addr, write, mask));
    expWriteQ.push_back(write);
    expParQ.push_back(expectPar(addr, expectMask(addr, write, mask), write, bad));
    @(negedge clk);
    reqValid = 1'b0;
  endtask

  task automatic sendRandom(logic withGaps);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    stimSeed = lcgNext(stimSeed);
    r1 = stimSeed;
    stimSeed = lcgNext(stimSeed);
    r2 = stimSeed;
    stimSeed = lcgNext(stimSeed);
    r3 = stimSeed;
    sendReq(paddrT'({r1[31:16], r2[31:16]}), r3[20], r3[27:24], r3[31:29] == 3'd0);
    if (withGaps) begin
      repeat (r3[17:16]) @(negedge clk);
    end
  endtask

  // Memory model serving one request at a time
  initial begin : memoryModel
    int      waited;
    int      nWords;
    paddrT   eAddr;
    rqMaskT  eMask;
    logic    eWrite;
    logic    ePar;
    memAckn      = 1'b0;
    memDataValid = 1'b0;
    memBusy      = 1'b0;
    memSeed      = 32'hfda5;
    forever begin
      waited = 0;
      @(negedge clk);
      while (!memStart) begin
        @(negedge clk);
        waited++;
        if (waited > StepLimit) begin
          failTimeout("memStart");
        end
      end
      memBusy = 1'b1;
      assert (expAddrQ.size() > 0) else failValue("memStart with no request outstanding");
      eAddr  = expAddrQ.pop_front();
      eMask  = expMaskQ.pop_front();
      eWrite = expWriteQ.pop_front();
      ePar   = expParQ.pop_front();
      assert (memAddr == eAddr && memWr == eWrite && memRd == !eWrite)
        else failValue($sformatf("memAddr %h rd %b wr %b, expected %h write %b",
                                 memAddr, memRd, memWr, eAddr, eWrite));
      assert (memRq == eMask)
        else failValue($sformatf("memRq %b, expected %b", memRq, eMask));
      assert (memAdrPar == ePar)
        else failValue($sformatf("memAdrPar %b, expected %b", memAdrPar, ePar));
      assert (memStartA != memStartB)
        else failValue("memStartA and memStartB not exactly one");
      if (!eWrite) begin
        pushWalk(eAddr, eMask);
      end
      nWords = $countones(eMask);
      for (int k = 0; k < nWords; k++) begin
        repeat (memGap()) @(negedge clk);
        memAckn = 1'b1;
        @(negedge clk);
        memAckn = 1'b0;
        if (k < nWords - 1) begin
          assert (memStart) else failValue("memStart dropped before the last acknowledge");
        end else begin
          assert (!memStart) else failValue("memStart still high after the last acknowledge");
        end
      end
      if (!eWrite) begin
        for (int k = 0; k < nWords; k++) begin
          repeat (memGap()) @(negedge clk);
          memDataValid = 1'b1;
          @(negedge clk);
          memDataValid = 1'b0;
        end
      end
      memBusy = 1'b0;
    end
  end

  // Core word order and bound assertion errors
  initial begin : coreMonitor
    wordSelT eWord;
    forever begin
      @(negedge clk);
      if (rstN && coreDataValid) begin
        assert (coreWordQ.size() > 0) else failValue("coreDataValid with no read word due");
        eWord = coreWordQ.pop_front();
        assert (coreWord == eWord)
          else failValue($sformatf("coreWord %0d, expected %0d", coreWord, eWord));
      end
      if (u_dut.uStart.uSva.errCount != 0) begin
        $display("A protocol assertion failed at %0t ns", $time);
        $display("Test FAILED");
        $fatal(1, "protocol assertion");
      end
    end
  end

  initial begin : stimulus
    int waited;
    int stallsBefore;
    reqValid       = 1'b0;
    reqAddr        = '0;
    reqWrite       = 1'b0;
    reqMask        = '0;
    reqForceBadPar = 1'b0;
    slowMem        = 1'b0;
    stimSeed       = 32'hfda5;
    stallCount     = 0;
    waited         = 0;
    while (rstN !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 100) begin
        failTimeout("reset release");
      end
    end
    @(negedge clk);

    // Directed cases for write, empty read, full and wrapping reads, forced bad parity
    sendReq(22'h000103, 1'b1, 4'b0000, 1'b0);
    sendReq(22'h00a0b2, 1'b0, 4'b0000, 1'b0);
    sendReq(22'h3fff01, 1'b0, 4'b1111, 1'b0);
    sendReq(22'h012343, 1'b0, 4'b0101, 1'b0);
    sendReq(22'h2aaaa8, 1'b1, 4'b1111, 1'b1);
    sendReq(22'h155556, 1'b0, 4'b1010, 1'b1);

    repeat (40) sendRandom(1'b1);

    // Slow memory with back to back requests
    slowMem      = 1'b1;
    stallsBefore = stallCount;
    repeat (24) sendRandom(1'b0);
    assert (stallCount > stallsBefore)
      else failValue("reqReady never dropped under a slow memory");

    waited = 0;
    while (expAddrQ.size() != 0 || coreWordQ.size() != 0 || memBusy) begin
      @(negedge clk);
      waited++;
      if (waited > 20 * StepLimit) begin
        failTimeout("all requests to complete");
      end
    end

    // A duplicated queue entry would reach memStart within a few cycles
    repeat (8) @(negedge clk);

    if (u_dut.uStart.uSva.errCount == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "protocol assertion");
    end
  end

endmodule

`default_nettype wire

//--- build.f
mboxPkg.sv
reqIssue.sv
reqQueue.sv
memStartCtl.sv
mboxMemCtl.sv
tbClock.sv
mboxMemCtl_sva.sv
mboxMemCtl_tb.sv

//--- Bender.yml
package:
  name: mbox_mem_ctl

sources:
  - mboxPkg.sv
  - reqIssue.sv
  - reqQueue.sv
  - memStartCtl.sv
  - mboxMemCtl.sv
  - target: test
    files:
      - tbClock.sv
      - mboxMemCtl_sva.sv
      - mboxMemCtl_tb.sv
